// ==== logic/alu_defines.svh ====
// operand width, queue depth, output credit and tag width macros
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// operand and result width
`define ALU_WIDTH 16

// request queue depth, also the input credits upstream starts with
`define REQ_DEPTH 4

// response queue depth
`define RSP_DEPTH 4

// output credits held by the unit out of reset
`define OUT_CREDITS 2

`define TAG_W 4

`endif

// ==== logic/alu_pkg.sv ====
// opcode and output-select enums, request and response structs
`include "alu_defines.svh"

package alu_pkg;

  typedef enum logic [2:0] {
    op_add  = 3'b000,
    op_sub  = 3'b001,
    op_sra  = 3'b010,
    op_srl  = 3'b011,
    op_sll  = 3'b100,
    op_and  = 3'b101,
    op_or   = 3'b110,
    op_rsvd = 3'b111  // returns zero
  } alu_op_e;

  // source of the result word
  typedef enum logic [1:0] {
    osel_arith = 2'b00,
    osel_shift = 2'b01,
    osel_logic = 2'b10,
    osel_zero  = 2'b11
  } osel_e;

  typedef struct packed {
    alu_op_e                op;
    logic [`ALU_WIDTH-1:0]  a;
    logic [`ALU_WIDTH-1:0]  b;   // low 4 bits are the shift amount
    logic [`TAG_W-1:0]      tag;
  } alu_req_t;

  typedef struct packed {
    logic [`ALU_WIDTH-1:0]  result;
    logic                   carry;  // no-borrow for subtract
    logic [`TAG_W-1:0]      tag;
  } alu_rsp_t;

endpackage

// ==== logic/credit_fifo.sv ====
// synchronous circular queue with a type-parameter payload and registered read data
module credit_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  depth  = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           push,
  input  item_t                          push_data,
  input  logic                           pop,
  output item_t                          pop_data,
  output logic                           empty,
  output logic [$clog2(depth + 1) - 1:0] count
);

  localparam int cnt_w = $clog2(depth + 1);
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  item_t            mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic             full;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
    if (pop) pop_data <= mem[rd_ptr];  // head shows up the cycle after the pop
  end

  // the credit scheme upstream must keep these from ever happening
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
    else $error("credit_fifo: push while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
    else $error("credit_fifo: pop while empty");

endmodule

// ==== logic/alu_control.sv ====
// opcode decode, queue pop control, input credit return and output credit counter
`include "alu_defines.svh"

module alu_control import alu_pkg::*; (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               req_empty,
  input  alu_op_e                            req_op,
  input  logic [$clog2(`RSP_DEPTH + 1) - 1:0] rsp_count,
  input  logic                               exe_valid,
  input  logic                               rsp_empty,
  input  logic                               out_credit,
  output logic                               req_pop,
  output logic                               rsp_pop,
  output logic                               in_credit,
  output logic                               out_valid,
  output logic                               cisel,
  output logic                               shift_la,
  output logic                               shift_lr,
  output logic                               logical_op,
  output osel_e                              osel
);

  localparam int cnt_w = $clog2(`RSP_DEPTH + 1);
  localparam int crd_w = $clog2(`OUT_CREDITS + 1);

  logic [crd_w-1:0] credit_cnt;
  logic [cnt_w+1:0] rsp_need;  // slots claimed if another request is popped now

  always_comb begin
    cisel      = 1'b0;
    shift_la   = 1'b0;
    shift_lr   = 1'b0;
    logical_op = 1'b0;
    osel       = osel_zero;
    case (req_op)
      op_add: osel = osel_arith;
      op_sub: begin
        osel  = osel_arith;
        cisel = 1'b1;  // invert b, carry in
      end
      op_sra: begin
        osel     = osel_shift;
        shift_la = 1'b1;
        shift_lr = 1'b1;
      end
      op_srl: begin
        osel     = osel_shift;
        shift_lr = 1'b1;
      end
      op_sll: begin
        osel     = osel_shift;
        shift_la = 1'b1;
      end
      op_and: begin
        osel       = osel_logic;
        logical_op = 1'b1;
      end
      op_or: osel = osel_logic;
      default: osel = osel_zero;
    endcase
  end

  // in_credit doubles as the execute load, so count that stage too
  assign rsp_need = (cnt_w + 2)'(rsp_count) + (cnt_w + 2)'(exe_valid)
                  + (cnt_w + 2)'(in_credit) + 1'b1;
  assign req_pop  = !req_empty && (rsp_need <= (cnt_w + 2)'(`RSP_DEPTH));
  assign rsp_pop  = !rsp_empty && (credit_cnt != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_credit  <= 1'b0;
      out_valid  <= 1'b0;
      credit_cnt <= crd_w'(`OUT_CREDITS);
    end else begin
      in_credit  <= req_pop;
      out_valid  <= rsp_pop;  // lines up with the registered queue head
      credit_cnt <= credit_cnt + crd_w'(out_credit) - crd_w'(rsp_pop);
    end
  end

  a_decode_known: assert property (@(posedge clk) disable iff (!rst_n)
    req_pop |=> !$isunknown({cisel, shift_la, shift_lr, logical_op, osel}))
    else $error("alu_control: unknown decode on the popped request");
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= crd_w'(`OUT_CREDITS))
    else $error("alu_control: output credits above the reset count");

endmodule

// ==== logic/add_sub_unit.sv ====
// 16-bit adder/subtractor with carry out
`include "alu_defines.svh"

module add_sub_unit import alu_pkg::*; (
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  input  logic                  cisel,
  output logic [`ALU_WIDTH-1:0] sum,
  output logic                  carry
);

  logic [`ALU_WIDTH-1:0] b_eff;
  logic [`ALU_WIDTH:0]   total;

  // subtract is a + ~b + 1
  assign b_eff = cisel ? ~b : b;

  // carry high on subtract means a >= b, no borrow
  assign total = {1'b0, a} + {1'b0, b_eff} + (`ALU_WIDTH + 1)'(cisel);

  assign sum   = total[`ALU_WIDTH-1:0];
  assign carry = total[`ALU_WIDTH];

endmodule

// ==== logic/shift_unit.sv ====
// four-level barrel shifter for left, logical right and arithmetic right shifts
`include "alu_defines.svh"

module shift_unit import alu_pkg::*; (
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [3:0]            amount,
  input  logic                  shift_la,
  input  logic                  shift_lr,
  output logic [`ALU_WIDTH-1:0] shifted
);

  logic                  fill;
  logic [`ALU_WIDTH-1:0] fill_word;
  logic [`ALU_WIDTH-1:0] stage;

  assign fill      = shift_la & a[`ALU_WIDTH-1];  // sign fill only for sra
  assign fill_word = {`ALU_WIDTH{fill}};

  // level i moves by 2**i when amount[i] is set
  always_comb begin
    stage = a;
    for (int i = 0; i < 4; i++) begin
      if (amount[i]) begin
        if (shift_lr) begin
          stage = (stage >> (1 << i)) | (fill_word << (`ALU_WIDTH - (1 << i)));
        end else begin
          stage = stage << (1 << i);
        end
      end
    end
  end

  assign shifted = stage;

endmodule

// ==== logic/result_select.sv ====
// and/or logic, result source mux and the execute-stage response register
`include "alu_defines.svh"

module result_select import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  osel_e                 osel,
  input  logic                  logical_op,
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  input  logic [`ALU_WIDTH-1:0] sum,
  input  logic [`ALU_WIDTH-1:0] shifted,
  input  logic                  carry,
  input  logic [`TAG_W-1:0]     tag,
  output logic                  exe_valid,
  output alu_rsp_t              exe_rsp
);

  logic [`ALU_WIDTH-1:0] logic_res;
  logic [`ALU_WIDTH-1:0] result_d;
  logic                  carry_d;

  assign logic_res = logical_op ? (a & b) : (a | b);

  always_comb begin
    case (osel)
      osel_arith: result_d = sum;
      osel_shift: result_d = shifted;
      osel_logic: result_d = logic_res;
      default:    result_d = '0;  // reserved opcode
    endcase
  end

  // carry only means something for add and sub
  assign carry_d = (osel == osel_arith) && carry;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe_valid <= 1'b0;
    end else begin
      exe_valid <= load;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      exe_rsp.result <= result_d;
      exe_rsp.carry  <= carry_d;
      exe_rsp.tag    <= tag;
    end
  end

endmodule

// ==== logic/alu_top.sv ====
// execution unit top: request and response queues, control and datapath
`include "alu_defines.svh"

module alu_top import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  alu_op_e               in_op,
  input  logic [`ALU_WIDTH-1:0] in_a,
  input  logic [`ALU_WIDTH-1:0] in_b,
  input  logic [`TAG_W-1:0]     in_tag,
  output logic                  in_credit,
  input  logic                  out_credit,
  output logic                  out_valid,
  output logic [`ALU_WIDTH-1:0] out_result,
  output logic                  out_carry,
  output logic [`TAG_W-1:0]     out_tag
);

  alu_req_t                           in_req;
  alu_req_t                           req_head;
  alu_rsp_t                           exe_rsp;
  alu_rsp_t                           rsp_head;
  logic                               req_empty;
  logic                               req_pop;
  logic                               rsp_empty;
  logic                               rsp_pop;
  logic [$clog2(`RSP_DEPTH + 1) - 1:0] rsp_count;
  logic                               exe_valid;
  logic                               cisel;
  logic                               shift_la;
  logic                               shift_lr;
  logic                               logical_op;
  osel_e                              osel;
  logic [`ALU_WIDTH-1:0]              sum;
  logic                               carry;
  logic [`ALU_WIDTH-1:0]              shifted;

  assign in_req = '{op: in_op, a: in_a, b: in_b, tag: in_tag};

  credit_fifo #(.item_t(alu_req_t), .depth(`REQ_DEPTH)) req_fifo (
    .clk, .rst_n, .push(in_valid), .push_data(in_req), .pop(req_pop),
    .pop_data(req_head), .empty(req_empty), .count()
  );

  alu_control ctrl (
    .clk, .rst_n, .req_empty, .req_op(req_head.op), .rsp_count, .exe_valid,
    .rsp_empty, .out_credit, .req_pop, .rsp_pop, .in_credit, .out_valid,
    .cisel, .shift_la, .shift_lr, .logical_op, .osel
  );

  add_sub_unit arith (
    .a(req_head.a), .b(req_head.b), .cisel, .sum, .carry
  );

  shift_unit shifter (
    .a(req_head.a), .amount(req_head.b[3:0]), .shift_la, .shift_lr, .shifted
  );

  // in_credit is the registered pop, so it also loads the execute stage
  result_select exe (
    .clk, .rst_n, .load(in_credit), .osel, .logical_op, .a(req_head.a),
    .b(req_head.b), .sum, .shifted, .carry, .tag(req_head.tag), .exe_valid, .exe_rsp
  );

  credit_fifo #(.item_t(alu_rsp_t), .depth(`RSP_DEPTH)) rsp_fifo (
    .clk, .rst_n, .push(exe_valid), .push_data(exe_rsp), .pop(rsp_pop),
    .pop_data(rsp_head), .empty(rsp_empty), .count(rsp_count)
  );

  assign out_result = rsp_head.result;
  assign out_carry  = rsp_head.carry;
  assign out_tag    = rsp_head.tag;

endmodule

// ==== verification/clock_gen.sv ====
// 4 ns clock and a reset held low for the first 4 cycles
module clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);  // release away from the active edge
    rst_n = 1'b1;
  end

endmodule

// ==== verification/alu_tb.sv ====
// execution unit testbench: random stimulus, credit models, reference model and checks
`include "alu_defines.svh"

module alu_tb import alu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_directed  = 10;
  localparam int n_random    = 300;
  localparam int n_pressure  = 200;
  localparam int cycle_limit = 4 * (n_directed + n_random + n_pressure) + 200;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  alu_op_e               in_op;
  logic [`ALU_WIDTH-1:0] in_a;
  logic [`ALU_WIDTH-1:0] in_b;
  logic [`TAG_W-1:0]     in_tag;
  logic                  in_credit;
  logic                  out_credit;
  logic                  out_valid;
  logic [`ALU_WIDTH-1:0] out_result;
  logic                  out_carry;
  logic [`TAG_W-1:0]     out_tag;

  alu_req_t    pending[$];   // stimulus not yet sent
  alu_rsp_t    expected[$];  // responses in send order
  logic [31:0] lfsr_state = 32'd99788;
  int          up_credits   = `REQ_DEPTH;
  int          dut_credits  = `OUT_CREDITS;  // output credits the DUT holds
  int          hold_left    = 0;
  int          cycles       = 0;
  int          next_tag     = 0;
  bit          backpressure = 1'b0;

  clock_gen clocks (.clk, .rst_n);

  alu_top dut0 (
    .clk, .rst_n, .in_valid, .in_op, .in_a, .in_b, .in_tag, .in_credit,
    .out_credit, .out_valid, .out_result, .out_carry, .out_tag
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic alu_rsp_t model_response(input alu_req_t r);
    alu_rsp_t            rsp;
    logic [`ALU_WIDTH:0] wide;
    logic [3:0]          sh;
    sh         = r.b[3:0];
    rsp.tag    = r.tag;
    rsp.carry  = 1'b0;
    rsp.result = '0;
    case (r.op)
      op_add: begin
        wide       = {1'b0, r.a} + {1'b0, r.b};
        rsp.result = wide[`ALU_WIDTH-1:0];
        rsp.carry  = wide[`ALU_WIDTH];
      end
      op_sub: begin
        rsp.result = r.a - r.b;
        rsp.carry  = (r.a >= r.b);  // no borrow
      end
      op_sra:  rsp.result = $signed(r.a) >>> sh;
      op_srl:  rsp.result = r.a >> sh;
      op_sll:  rsp.result = r.a << sh;
      op_and:  rsp.result = r.a & r.b;
      op_or:   rsp.result = r.a | r.b;
      default: rsp.result = '0;
    endcase
    return rsp;
  endfunction

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, want);
      abort_run();
    end
  endtask

  task automatic queue_request(input alu_op_e op, input logic [`ALU_WIDTH-1:0] a,
                               input logic [`ALU_WIDTH-1:0] b);
    alu_req_t r;
    r.op  = op;
    r.a   = a;
    r.b   = b;
    r.tag = `TAG_W'(next_tag);
    next_tag++;
    pending.push_back(r);
  endtask

  // samples at the falling edge, then drives the next inputs
  task automatic run_cycle();
    alu_req_t r;
    alu_rsp_t want;
    bit       pulse_prev;
    @(negedge clk);
    pulse_prev = out_credit;
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d responses outstanding", cycles,
               expected.size());
      abort_run();
    end
    if (in_credit) begin
      up_credits++;
      if (up_credits > `REQ_DEPTH) begin
        $display("DUT returned more input credits than requests outstanding at %0t ns",
                 $time);
        abort_run();
      end
    end
    if (out_valid) begin
      if (dut_credits == 0) begin
        $display("out_valid at %0t ns while downstream had granted no credit", $time);
        abort_run();
      end
      if (expected.size() == 0) begin
        $display("out_valid at %0t ns with no expected response", $time);
        abort_run();
      end
      want = expected.pop_front();
      check_value("out_result", 32'(out_result), 32'(want.result));
      check_value("out_carry", 32'(out_carry), 32'(want.carry));
      check_value("out_tag", 32'(out_tag), 32'(want.tag));
      dut_credits--;
    end
    dut_credits += int'(pulse_prev);  // pulse from last cycle counted at the rising edge

    out_credit = 1'b0;
    if (dut_credits < `OUT_CREDITS) begin
      if (hold_left > 0) begin
        hold_left--;
      end else if (backpressure && rand_bits(2) == 0) begin
        hold_left = int'(rand_bits(4));  // withhold for a random stretch
      end else begin
        out_credit = 1'b1;
      end
    end

    in_valid = 1'b0;
    if (pending.size() != 0 && up_credits > 0) begin
      r = pending.pop_front();
      in_op    = r.op;
      in_a     = r.a;
      in_b     = r.b;
      in_tag   = r.tag;
      in_valid = 1'b1;
      up_credits--;
      expected.push_back(model_response(r));
    end
  endtask

  task automatic drain();
    while (pending.size() != 0 || expected.size() != 0 || dut_credits != `OUT_CREDITS ||
           out_credit) begin
      run_cycle();
    end
  endtask

  task automatic queue_random(input int n);
    for (int i = 0; i < n; i++) begin
      queue_request(alu_op_e'(rand_bits(3)), `ALU_WIDTH'(rand_bits(16)),
                    `ALU_WIDTH'(rand_bits(16)));
    end
  endtask

  initial begin
    in_valid   = 1'b0;
    in_op      = op_add;
    in_a       = '0;
    in_b       = '0;
    in_tag     = '0;
    out_credit = 1'b0;

    // outputs stay quiet through reset and until the first request
    while (rst_n !== 1'b1) begin
      run_cycle();
      check_value("out_valid", 32'(out_valid), 32'd0);
      check_value("in_credit", 32'(in_credit), 32'd0);
    end
    repeat (6) begin
      run_cycle();
      check_value("out_valid", 32'(out_valid), 32'd0);
      check_value("in_credit", 32'(in_credit), 32'd0);
    end

    $display("directed opcode checks");
    queue_request(op_add, 16'hffff, 16'h0001);   // carry out
    queue_request(op_add, 16'h1234, 16'h0101);
    queue_request(op_sub, 16'h0005, 16'h0003);
    queue_request(op_sub, 16'h0003, 16'h0005);   // borrow
    queue_request(op_sra, 16'h8000, 16'h0004);
    queue_request(op_srl, 16'h8000, 16'h0004);
    queue_request(op_sll, 16'h0001, 16'h000f);
    queue_request(op_and, 16'hf0f0, 16'h3c3c);
    queue_request(op_or, 16'hf0f0, 16'h0f01);
    queue_request(op_rsvd, 16'hffff, 16'hffff);  // must come back all zero
    drain();

    $display("random requests at full rate");
    queue_random(n_random);
    drain();

    $display("random requests under back-pressure");
    backpressure = 1'b1;
    queue_random(n_pressure);
    drain();
    backpressure = 1'b0;
    drain();

    repeat (4) run_cycle();
    check_value("upstream credits", 32'(up_credits), 32'(`REQ_DEPTH));
    check_value("output credits held", 32'(dut0.ctrl.credit_cnt), 32'(`OUT_CREDITS));

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+logic
logic/alu_pkg.sv
logic/credit_fifo.sv
logic/alu_control.sv
logic/add_sub_unit.sv
logic/shift_unit.sv
logic/result_select.sv
logic/alu_top.sv
verification/clock_gen.sv
verification/alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the execution unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f list.f --top-module alu_tb -o alu_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/alu_sim 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if echo "$sim_output" | grep -q "^ALL TESTS PASSED$"; then
  exit 0
fi

echo "pass message not found in the simulation output"
exit 1
